//--- include/t04_consts.svh
`ifndef T04_CONSTS_SVH
`define T04_CONSTS_SVH

// screen extents in pixels
`define SCREEN_W 240
`define SCREEN_H 320

// pixels per key press
`define CURSOR_STEP 16

// synchronised cycles a row must hold
`define DEBOUNCE_CYCLES 4

// 8080 write strobe phases, in clocks
`define WR_LOW_CYCLES 2
`define WR_HIGH_CYCLES 2

// rgb565 red
`define CURSOR_COLOR 16'hF800

// ili9341 command bytes
`define OP_SLPOUT 8'h11
`define OP_COLMOD 8'h3A
`define OP_DISPON 8'h29
`define OP_CASET 8'h2A
`define OP_PASET 8'h2B
`define OP_RAMWR 8'h2C

// 16 bits per pixel
`define COLMOD_PARAM 8'h55

`endif

//--- logic/keypadPkg.sv
package keypadPkg;

  // one code per push-button row
  // row 0 is up, row 3 is right
  typedef enum logic [1:0] {
    keyUp    = 2'd0,
    keyDown  = 2'd1,
    keyLeft  = 2'd2,
    keyRight = 2'd3
  } keyT;

  // valid is a single-cycle press pulse
  typedef struct packed {
    logic valid;
    keyT  key;
  } keyEventT;

endpackage

//--- logic/lcdPkg.sv
`include "t04_consts.svh"

package lcdPkg;

  // display commands used by the sequencer
  typedef enum logic [7:0] {
    opSlpout = `OP_SLPOUT,
    opColmod = `OP_COLMOD,
    opDispon = `OP_DISPON,
    opCaset  = `OP_CASET,
    opPaset  = `OP_PASET,
    opRamwr  = `OP_RAMWR
  } lcdOpT;

  // sequencer states
  // sWait holds until the writer finishes a byte
  typedef enum logic [1:0] {
    sIdle = 2'd0,
    sInit = 2'd1,
    sDraw = 2'd2,
    sWait = 2'd3
  } seqStateT;

  // one bus byte, isData drives dcx
  typedef struct packed {
    logic       isData;
    logic [7:0] value;
  } lcdByteT;

  // cursor position to draw
  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
  } drawReqT;

endpackage

//--- logic/keypadScanner.sv
`timescale 1ns/1ps
`include "t04_consts.svh"

module keypadScanner (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [3:0]           row,
  output keypadPkg::keyEventT  keyEvent
);

  localparam int CountW = $clog2(`DEBOUNCE_CYCLES + 1);
  localparam logic [CountW-1:0] CountLast = CountW'(`DEBOUNCE_CYCLES - 1);

  logic [3:0]        rowMeta;
  logic [3:0]        rowSync;
  logic              anyActive;
  keypadPkg::keyT    candidate;
  keypadPkg::keyT    heldKey;
  logic [CountW-1:0] count;
  logic              waitRelease;

  // two-flop synchroniser on the raw rows
  always_ff @(posedge clk) begin
    if (reset) begin
      rowMeta <= 4'b0000;
      rowSync <= 4'b0000;
    end else begin
      rowMeta <= row;
      rowSync <= rowMeta;
    end
  end

  assign anyActive = |rowSync;

  // lowest active row wins
  always_comb begin
    candidate = keypadPkg::keyUp;
    if (rowSync[0]) begin
      candidate = keypadPkg::keyUp;
    end else if (rowSync[1]) begin
      candidate = keypadPkg::keyDown;
    end else if (rowSync[2]) begin
      candidate = keypadPkg::keyLeft;
    end else if (rowSync[3]) begin
      candidate = keypadPkg::keyRight;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      heldKey     <= keypadPkg::keyUp;
      count       <= '0;
      waitRelease <= 1'b0;
      keyEvent    <= '{valid: 1'b0, key: keypadPkg::keyUp};
    end else begin
      // pulse lasts one cycle
      keyEvent.valid <= 1'b0;
      if (waitRelease) begin
        // rearm only once every row is released
        count <= '0;
        if (!anyActive) begin
          waitRelease <= 1'b0;
        end
      end else if (!anyActive) begin
        // early release drops the count
        count <= '0;
      end else if (count == '0 || candidate != heldKey) begin
        heldKey <= candidate;
        count   <= CountW'(1);
      end else if (count == CountLast) begin
        keyEvent    <= '{valid: 1'b1, key: heldKey};
        count       <= '0;
        waitRelease <= 1'b1;
      end else begin
        count <= count + CountW'(1);
      end
    end
  end

endmodule

//--- logic/cursorControl.sv
`timescale 1ns/1ps
`include "t04_consts.svh"

module cursorControl (
  input  logic                clk,
  input  logic                reset,
  input  keypadPkg::keyEventT keyEvent,
  input  logic                busy,
  output lcdPkg::drawReqT     drawReq,
  output logic                drawStrobe,
  output logic                atEdgeX,
  output logic                atEdgeY
);

  localparam logic [15:0] MaxX   = 16'(`SCREEN_W - 1);
  localparam logic [15:0] MaxY   = 16'(`SCREEN_H - 1);
  localparam logic [15:0] Step   = 16'(`CURSOR_STEP);
  localparam logic [15:0] StartX = 16'(`SCREEN_W / 2);
  localparam logic [15:0] StartY = 16'(`SCREEN_H / 2);

  logic        accept;
  logic [15:0] nextX;
  logic [15:0] nextY;

  // drawStrobe covers the cycle before busy rises
  assign accept = keyEvent.valid && !busy && !drawStrobe;

  // saturating move, no wrap at the edges
  always_comb begin
    nextX = drawReq.x;
    nextY = drawReq.y;
    case (keyEvent.key)
      keypadPkg::keyLeft: begin
        nextX = (drawReq.x < Step) ? 16'd0 : drawReq.x - Step;
      end
      keypadPkg::keyRight: begin
        nextX = (drawReq.x >= MaxX - Step) ? MaxX : drawReq.x + Step;
      end
      keypadPkg::keyUp: begin
        nextY = (drawReq.y < Step) ? 16'd0 : drawReq.y - Step;
      end
      keypadPkg::keyDown: begin
        nextY = (drawReq.y >= MaxY - Step) ? MaxY : drawReq.y + Step;
      end
      default: begin
        nextX = drawReq.x;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      drawReq    <= '{x: StartX, y: StartY};
      drawStrobe <= 1'b0;
      atEdgeX    <= 1'b0;
      atEdgeY    <= 1'b0;
    end else begin
      drawStrobe <= accept;
      if (accept) begin
        drawReq <= '{x: nextX, y: nextY};
      end
      // edge lights follow the stored position
      atEdgeX <= (drawReq.x == 16'd0) || (drawReq.x == MaxX);
      atEdgeY <= (drawReq.y == 16'd0) || (drawReq.y == MaxY);
    end
  end

endmodule

//--- logic/lcdSequencer.sv
`timescale 1ns/1ps
`include "t04_consts.svh"

module lcdSequencer (
  input  logic            clk,
  input  logic            reset,
  input  lcdPkg::drawReqT drawReq,
  input  logic            drawStrobe,
  input  logic            byteDone,
  input  logic            writerBusy,
  output lcdPkg::lcdByteT outByte,
  output logic            byteStrobe,
  output logic            busy,
  output logic            initDone
);

  localparam logic [3:0]  InitLast = 4'd3;
  localparam logic [3:0]  DrawLast = 4'd12;
  localparam logic [15:0] Colour   = `CURSOR_COLOR;

  lcdPkg::seqStateT state;
  lcdPkg::drawReqT  req;
  lcdPkg::lcdByteT  listByte;
  logic [3:0]       byteIdx;
  logic [3:0]       lastIdx;

  assign lastIdx = initDone ? DrawLast : InitLast;

  // request is held for the whole draw
  always_ff @(posedge clk) begin
    if (state == lcdPkg::sIdle && drawStrobe) begin
      req <= drawReq;
    end
  end

  // init table until initDone then the draw table
  always_comb begin
    listByte = '{isData: 1'b0, value: lcdPkg::opSlpout};
    if (!initDone) begin
      case (byteIdx)
        4'd0: listByte = '{isData: 1'b0, value: lcdPkg::opSlpout};
        4'd1: listByte = '{isData: 1'b0, value: lcdPkg::opColmod};
        4'd2: listByte = '{isData: 1'b1, value: `COLMOD_PARAM};
        default: listByte = '{isData: 1'b0, value: lcdPkg::opDispon};
      endcase
    end else begin
      // start and end address are the same pixel
      case (byteIdx)
        4'd0: listByte = '{isData: 1'b0, value: lcdPkg::opCaset};
        4'd1, 4'd3: listByte = '{isData: 1'b1, value: req.x[15:8]};
        4'd2, 4'd4: listByte = '{isData: 1'b1, value: req.x[7:0]};
        4'd5: listByte = '{isData: 1'b0, value: lcdPkg::opPaset};
        4'd6, 4'd8: listByte = '{isData: 1'b1, value: req.y[15:8]};
        4'd7, 4'd9: listByte = '{isData: 1'b1, value: req.y[7:0]};
        4'd10: listByte = '{isData: 1'b0, value: lcdPkg::opRamwr};
        4'd11: listByte = '{isData: 1'b1, value: Colour[15:8]};
        default: listByte = '{isData: 1'b1, value: Colour[7:0]};
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // init starts straight out of reset
      state      <= lcdPkg::sInit;
      byteIdx    <= 4'd0;
      byteStrobe <= 1'b0;
      busy       <= 1'b0;
      initDone   <= 1'b0;
      outByte    <= '{isData: 1'b0, value: 8'h00};
    end else begin
      byteStrobe <= 1'b0;
      case (state)
        lcdPkg::sIdle: begin
          if (drawStrobe) begin
            byteIdx <= 4'd0;
            busy    <= 1'b1;
            state   <= lcdPkg::sDraw;
          end
        end
        lcdPkg::sInit, lcdPkg::sDraw: begin
          busy <= 1'b1;
          // one byte in flight at a time
          if (!writerBusy) begin
            outByte    <= listByte;
            byteStrobe <= 1'b1;
            state      <= lcdPkg::sWait;
          end
        end
        lcdPkg::sWait: begin
          if (byteDone) begin
            if (byteIdx == lastIdx) begin
              byteIdx  <= 4'd0;
              busy     <= 1'b0;
              initDone <= 1'b1;
              state    <= lcdPkg::sIdle;
            end else begin
              byteIdx <= byteIdx + 4'd1;
              state   <= initDone ? lcdPkg::sDraw : lcdPkg::sInit;
            end
          end
        end
        default: begin
          state <= lcdPkg::sIdle;
        end
      endcase
    end
  end

endmodule

//--- logic/lcdBusWriter.sv
`timescale 1ns/1ps
`include "t04_consts.svh"

module lcdBusWriter (
  input  logic            clk,
  input  logic            reset,
  input  lcdPkg::lcdByteT inByte,
  input  logic            byteStrobe,
  output logic            writerBusy,
  output logic            byteDone,
  output logic            screenCsx,
  output logic            screenDcx,
  output logic            screenWrx,
  output logic [7:0]      screenData
);

  // phase 0 is setup, then low phases, then high phases
  localparam int PhaseEnd = 1 + `WR_LOW_CYCLES + `WR_HIGH_CYCLES;
  localparam int PhaseW   = $clog2(PhaseEnd + 1);

  logic [PhaseW-1:0] phase;
  logic [PhaseW-1:0] phaseNext;

  assign phaseNext = phase + PhaseW'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase      <= '0;
      writerBusy <= 1'b0;
      byteDone   <= 1'b0;
      screenCsx  <= 1'b1;
      screenDcx  <= 1'b1;
      screenWrx  <= 1'b1;
      screenData <= 8'h00;
    end else begin
      byteDone <= 1'b0;
      if (!writerBusy) begin
        if (byteStrobe) begin
          // select chip and set up dcx and data
          phase      <= '0;
          writerBusy <= 1'b1;
          screenCsx  <= 1'b0;
          screenDcx  <= inByte.isData;
          screenData <= inByte.value;
          screenWrx  <= 1'b1;
        end
      end else begin
        phase <= phaseNext;
        // display latches on the rising wrx edge
        if (phaseNext >= PhaseW'(1) && phaseNext <= PhaseW'(`WR_LOW_CYCLES)) begin
          screenWrx <= 1'b0;
        end else begin
          screenWrx <= 1'b1;
        end
        if (phaseNext == PhaseW'(PhaseEnd)) begin
          screenCsx  <= 1'b1;
          byteDone   <= 1'b1;
          writerBusy <= 1'b0;
        end
      end
    end
  end

endmodule

//--- logic/t04Top.sv
`timescale 1ns/1ps

module t04Top (
  input  logic       clk,
  input  logic       reset,
  input  logic [3:0] row,
  output logic       screenCsx,
  output logic       screenDcx,
  output logic       screenWrx,
  output logic [7:0] screenData,
  output logic       checkC,
  output logic       checkX,
  output logic       checkY
);

  keypadPkg::keyEventT keyEvent;
  lcdPkg::drawReqT     drawReq;
  lcdPkg::lcdByteT     seqByte;
  logic                drawStrobe;
  logic                busy;
  logic                byteStrobe;
  logic                byteDone;
  logic                writerBusy;

  // rows to press pulses
  keypadScanner scanner (
    .clk      (clk),
    .reset    (reset),
    .row      (row),
    .keyEvent (keyEvent)
  );

  // position and edge lights
  cursorControl cursor (
    .clk        (clk),
    .reset      (reset),
    .keyEvent   (keyEvent),
    .busy       (busy),
    .drawReq    (drawReq),
    .drawStrobe (drawStrobe),
    .atEdgeX    (checkX),
    .atEdgeY    (checkY)
  );

  // init and per-move command bytes
  lcdSequencer sequencer (
    .clk        (clk),
    .reset      (reset),
    .drawReq    (drawReq),
    .drawStrobe (drawStrobe),
    .byteDone   (byteDone),
    .writerBusy (writerBusy),
    .outByte    (seqByte),
    .byteStrobe (byteStrobe),
    .busy       (busy),
    .initDone   (checkC)
  );

  // 8080 pin timing
  lcdBusWriter writer (
    .clk        (clk),
    .reset      (reset),
    .inByte     (seqByte),
    .byteStrobe (byteStrobe),
    .writerBusy (writerBusy),
    .byteDone   (byteDone),
    .screenCsx  (screenCsx),
    .screenDcx  (screenDcx),
    .screenWrx  (screenWrx),
    .screenData (screenData)
  );

endmodule

//--- logic/top.sv
`timescale 1ns/1ps

module top (
  input  logic       hwclk,
  input  logic       reset,
  input  logic [20:0] pb,
  output logic [7:0] left,
  output logic [7:0] right,
  output logic [7:0] ss7,
  output logic [7:0] ss6,
  output logic [7:0] ss5,
  output logic [7:0] ss4,
  output logic [7:0] ss3,
  output logic [7:0] ss2,
  output logic [7:0] ss1,
  output logic [7:0] ss0,
  output logic       red,
  output logic       green,
  output logic       blue,
  output logic [7:0] txdata,
  input  logic [7:0] rxdata,
  output logic       txclk,
  output logic       rxclk,
  input  logic       txready,
  input  logic       rxready
);

  // pb[19] is the reset button
  // pb[3:0] are the key rows
  t04Top team04 (
    .clk        (hwclk),
    .reset      (pb[19]),
    .row        (pb[3:0]),
    .screenCsx  (right[0]),
    .screenDcx  (right[1]),
    .screenWrx  (right[2]),
    .screenData (left),
    .checkC     (red),
    .checkX     (green),
    .checkY     (blue)
  );

  // seven-segment and uart unused
  assign right[7:3] = 5'b00000;
  assign ss7 = 8'h00;
  assign ss6 = 8'h00;
  assign ss5 = 8'h00;
  assign ss4 = 8'h00;
  assign ss3 = 8'h00;
  assign ss2 = 8'h00;
  assign ss1 = 8'h00;
  assign ss0 = 8'h00;
  assign txdata = 8'h00;
  assign txclk = 1'b0;
  assign rxclk = 1'b0;

endmodule

//--- sim/t04_properties.sv
`timescale 1ns/1ps
`include "t04_consts.svh"

module t04Properties (
  input logic        clk,
  input logic        reset,
  input logic [3:0]  row,
  input logic        csx,
  input logic        dcx,
  input logic        wrx,
  input logic [7:0]  data,
  input logic        checkC,
  input logic        checkX,
  input logic        checkY,
  input logic [78:0] unusedOut
);

  localparam logic [15:0] MaxX = 16'(`SCREEN_W - 1);
  localparam logic [15:0] MaxY = 16'(`SCREEN_H - 1);
  localparam logic [15:0] Step = 16'(`CURSOR_STEP);

  int unsigned     failCount = 0;
  int unsigned     byteCount;
  int unsigned     pressCount;
  int unsigned     holdCount;
  int unsigned     drawIdx;
  int unsigned     drawsStarted;
  logic            wrxPrev;
  logic            wrxRise;
  logic            edgeX;
  logic            edgeY;
  lcdPkg::drawReqT expPos;
  lcdPkg::lcdByteT seenByte;
  lcdPkg::lcdByteT wantByte;

  // clamped move by the lowest active row
  function automatic lcdPkg::drawReqT stepCursor(input logic [3:0] rows,
                                                 input lcdPkg::drawReqT pos);
    lcdPkg::drawReqT moved;
    moved = pos;
    if (rows[0]) begin
      moved.y = (pos.y < Step) ? 16'd0 : pos.y - Step;
    end else if (rows[1]) begin
      moved.y = (pos.y + Step > MaxY) ? MaxY : pos.y + Step;
    end else if (rows[2]) begin
      moved.x = (pos.x < Step) ? 16'd0 : pos.x - Step;
    end else if (rows[3]) begin
      moved.x = (pos.x + Step > MaxX) ? MaxX : pos.x + Step;
    end
    return moved;
  endfunction

  // expected byte n on the bus
  // four init bytes then 13 per draw
  function automatic lcdPkg::lcdByteT expectedByte(input int unsigned count,
                                                   input lcdPkg::drawReqT pos);
    lcdPkg::lcdByteT b;
    int unsigned     idx;
    logic [15:0]     colour;
    colour = `CURSOR_COLOR;
    b = '{isData: 1'b0, value: 8'h00};
    if (count < 4) begin
      case (count)
        0: b = '{isData: 1'b0, value: `OP_SLPOUT};
        1: b = '{isData: 1'b0, value: `OP_COLMOD};
        2: b = '{isData: 1'b1, value: `COLMOD_PARAM};
        default: b = '{isData: 1'b0, value: `OP_DISPON};
      endcase
    end else begin
      idx = (count - 4) % 13;
      case (idx)
        0: b = '{isData: 1'b0, value: `OP_CASET};
        1, 3: b = '{isData: 1'b1, value: pos.x[15:8]};
        2, 4: b = '{isData: 1'b1, value: pos.x[7:0]};
        5: b = '{isData: 1'b0, value: `OP_PASET};
        6, 8: b = '{isData: 1'b1, value: pos.y[15:8]};
        7, 9: b = '{isData: 1'b1, value: pos.y[7:0]};
        10: b = '{isData: 1'b0, value: `OP_RAMWR};
        11: b = '{isData: 1'b1, value: colour[15:8]};
        default: b = '{isData: 1'b1, value: colour[7:0]};
      endcase
    end
    return b;
  endfunction

  // display latches on wrx rising
  assign wrxRise  = wrx && !wrxPrev;
  assign seenByte = '{isData: dcx, value: data};
  assign edgeX    = (expPos.x == 16'd0) || (expPos.x == MaxX);
  assign edgeY    = (expPos.y == 16'd0) || (expPos.y == MaxY);

  always_comb begin
    drawIdx      = (byteCount >= 4) ? (byteCount - 4) % 13 : 0;
    drawsStarted = (byteCount >= 4) ? (byteCount - 4) / 13 : 0;
    wantByte     = expectedByte(byteCount, expPos);
  end

  // byte log and cursor model
  always_ff @(posedge clk) begin
    if (reset) begin
      wrxPrev    <= 1'b1;
      byteCount  <= 0;
      pressCount <= 0;
      holdCount  <= 0;
      expPos     <= '{x: 16'(`SCREEN_W / 2), y: 16'(`SCREEN_H / 2)};
    end else begin
      wrxPrev <= wrx;
      if (wrxRise) begin
        byteCount <= byteCount + 1;
      end
      // a row held DEBOUNCE_CYCLES counts once
      if (row == 4'b0000) begin
        holdCount <= 0;
      end else if (holdCount < `DEBOUNCE_CYCLES) begin
        holdCount <= holdCount + 1;
        if (holdCount == `DEBOUNCE_CYCLES - 1) begin
          pressCount <= pressCount + 1;
          expPos     <= stepCursor(row, expPos);
        end
      end
    end
  end

  // idle pins through reset and the cycle after
  resetIdle: assert property (@(posedge clk)
      reset |=> (csx && wrx && dcx && !checkC) ##1 (csx && wrx && dcx && !checkC))
    else begin
      failCount = failCount + 1;
      $error("ERROR screenCsx=%h screenWrx=%h screenDcx=%h checkC=%h expected 1 1 1 0",
             $sampled(csx), $sampled(wrx), $sampled(dcx), $sampled(checkC));
    end

  strobeInSelect: assert property (@(posedge clk) disable iff (reset) !wrx |-> !csx)
    else begin
      failCount = failCount + 1;
      $error("ERROR screenCsx=%h expected 0 while wrx low", $sampled(csx));
    end

  busStable: assert property (@(posedge clk) disable iff (reset)
      (!csx && $past(!csx)) |-> ($stable(dcx) && $stable(data)))
    else begin
      failCount = failCount + 1;
      $error("dcx or data changed while csx was low");
    end

  lowWidth: assert property (@(posedge clk) disable iff (reset)
      $fell(wrx) |-> (!wrx)[*`WR_LOW_CYCLES] ##1 wrx)
    else begin
      failCount = failCount + 1;
      $error("wrx low pulse not WR_LOW_CYCLES long");
    end

  byteValue: assert property (@(posedge clk) disable iff (reset)
      wrxRise |-> (seenByte == wantByte))
    else begin
      failCount = failCount + 1;
      $error("ERROR screenDcx=%h screenData=%h expected %h %h at byte %0d",
             $sampled(seenByte.isData), $sampled(seenByte.value),
             $sampled(wantByte.isData), $sampled(wantByte.value), $sampled(byteCount));
    end

  initDoneAt4: assert property (@(posedge clk) disable iff (reset)
      $rose(checkC) |-> (byteCount == 4))
    else begin
      failCount = failCount + 1;
      $error("ERROR byteCount=%h expected 4 when checkC rose", $sampled(byteCount));
    end

  noByteBeforeInit: assert property (@(posedge clk) disable iff (reset)
      (wrxRise && !checkC) |-> (byteCount < 4))
    else begin
      failCount = failCount + 1;
      $error("bus byte written before checkC rose");
    end

  // catches draws from short bounces too
  drawNeedsPress: assert property (@(posedge clk) disable iff (reset)
      (wrxRise && byteCount >= 4 && drawIdx == 0) |-> (drawsStarted < pressCount))
    else begin
      failCount = failCount + 1;
      $error("draw started without a debounced key press");
    end

  edgeLightX: assert property (@(posedge clk) disable iff (reset)
      (wrxRise && byteCount >= 4 && drawIdx == 12) |-> (checkX == edgeX))
    else begin
      failCount = failCount + 1;
      $error("ERROR checkX=%h expected %h", $sampled(checkX), $sampled(edgeX));
    end

  edgeLightY: assert property (@(posedge clk) disable iff (reset)
      (wrxRise && byteCount >= 4 && drawIdx == 12) |-> (checkY == edgeY))
    else begin
      failCount = failCount + 1;
      $error("ERROR checkY=%h expected %h", $sampled(checkY), $sampled(edgeY));
    end

  // board outputs outside the subsystem stay tied low
  unusedLow: assert property (@(posedge clk) unusedOut == '0)
    else begin
      failCount = failCount + 1;
      $error("ERROR unusedOut=%h expected 0", $sampled(unusedOut));
    end

endmodule

//--- sim/t04Tb.sv
`timescale 1ns/1ps
`include "t04_consts.svh"

module t04Tb;

  // pb bits of the key rows
  localparam int RowUp    = 0;
  localparam int RowDown  = 1;
  localparam int RowLeft  = 2;
  localparam int RowRight = 3;

  // one byte costs strobe, setup, low, high, done and next strobe
  localparam int ByteCycles   = 4 + `WR_LOW_CYCLES + `WR_HIGH_CYCLES;
  localparam int MaxHold      = `DEBOUNCE_CYCLES + 10;
  localparam int MaxGap       = 6;
  localparam int SettleCycles = 3 * `DEBOUNCE_CYCLES + 8;
  localparam int PressTotal   = 25;
  localparam int BounceTotal  = 7;
  localparam int InitCycles   = 4 + 4 * ByteCycles + 10;
  localparam int PressBudget  = 13 * ByteCycles + MaxHold + MaxGap
                                + 2 * `DEBOUNCE_CYCLES + 10;
  localparam int BounceBudget = `DEBOUNCE_CYCLES + SettleCycles + 4;
  localparam int CycleLimit   = InitCycles + PressTotal * PressBudget
                                + BounceTotal * BounceBudget;

  logic        hwclk;
  logic        reset;
  logic [20:0] pb;
  logic [7:0]  rxdata;
  logic        txready;
  logic        rxready;
  logic [7:0]  left;
  logic [7:0]  right;
  logic [7:0]  ss7;
  logic [7:0]  ss6;
  logic [7:0]  ss5;
  logic [7:0]  ss4;
  logic [7:0]  ss3;
  logic [7:0]  ss2;
  logic [7:0]  ss1;
  logic [7:0]  ss0;
  logic        red;
  logic        green;
  logic        blue;
  logic [7:0]  txdata;
  logic        txclk;
  logic        rxclk;
  int unsigned cycleCount;
  int unsigned pressesDone;

  top UUT (
    .hwclk   (hwclk),
    .reset   (reset),
    .pb      (pb),
    .left    (left),
    .right   (right),
    .ss7     (ss7),
    .ss6     (ss6),
    .ss5     (ss5),
    .ss4     (ss4),
    .ss3     (ss3),
    .ss2     (ss2),
    .ss1     (ss1),
    .ss0     (ss0),
    .red     (red),
    .green   (green),
    .blue    (blue),
    .txdata  (txdata),
    .rxdata  (rxdata),
    .txclk   (txclk),
    .rxclk   (rxclk),
    .txready (txready),
    .rxready (rxready)
  );

  // checkers sit on the board pins
  bind top t04Properties props (
    .clk       (hwclk),
    .reset     (pb[19]),
    .row       (pb[3:0]),
    .csx       (right[0]),
    .dcx       (right[1]),
    .wrx       (right[2]),
    .data      (left),
    .checkC    (red),
    .checkX    (green),
    .checkY    (blue),
    .unusedOut ({right[7:3], ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0,
                 txdata, txclk, rxclk})
  );

  always #5 hwclk = ~hwclk;

  // run limit in clocks
  always @(posedge hwclk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout after %0d cycles with %0d of %0d presses issued",
               cycleCount, pressesDone, PressTotal);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // returns on a rising edge once the log reaches target
  task automatic waitBytes(input int unsigned target);
    while (UUT.props.byteCount < target) begin
      @(posedge hwclk);
    end
  endtask

  // full press then wait for its 13 bytes
  task automatic pressKey(input int rowIdx);
    int unsigned hold;
    int unsigned gap;
    hold = $urandom_range(MaxHold, `DEBOUNCE_CYCLES);
    gap  = $urandom_range(MaxGap, 2);
    pb[rowIdx] <= 1'b1;
    repeat (hold) @(posedge hwclk);
    pb[rowIdx] <= 1'b0;
    pressesDone = pressesDone + 1;
    waitBytes(4 + 13 * pressesDone);
    repeat (gap) @(posedge hwclk);
  endtask

  // too short for the debouncer
  task automatic bounceKey(input int rowIdx);
    int unsigned len;
    len = $urandom_range(`DEBOUNCE_CYCLES - 1, 1);
    pb[rowIdx] <= 1'b1;
    repeat (len) @(posedge hwclk);
    pb[rowIdx] <= 1'b0;
    repeat (SettleCycles) @(posedge hwclk);
  endtask

  initial begin
    void'($urandom(32'hd06d));
    hwclk       = 1'b0;
    reset       = 1'b0;
    pb          = 21'd0;
    pb[19]      = 1'b1;
    rxdata      = 8'h00;
    txready     = 1'b0;
    rxready     = 1'b0;
    cycleCount  = 0;
    pressesDone = 0;

    // pb[19] is the reset button
    repeat (2) @(posedge hwclk);
    pb[19] <= 1'b0;

    // init bytes first
    while (!red) begin
      @(posedge hwclk);
    end
    bounceKey(RowDown);

    // walk to the left and top edges
    repeat (8) pressKey(RowLeft);
    repeat (10) pressKey(RowUp);
    pressKey(RowRight);

    // random keys with a bounce before each
    for (int i = 0; i < 6; i++) begin
      bounceKey($urandom_range(3, 0));
      pressKey($urandom_range(3, 0));
    end
    repeat (4) @(posedge hwclk);

    $display("presses %0d, bus bytes %0d, errors %0d", pressesDone,
             UUT.props.byteCount, UUT.props.failCount);
    if (UUT.props.failCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
logic/keypadPkg.sv
logic/lcdPkg.sv
logic/keypadScanner.sv
logic/cursorControl.sv
logic/lcdSequencer.sv
logic/lcdBusWriter.sv
logic/t04Top.sv
logic/top.sv
sim/t04_properties.sv
sim/t04Tb.sv
